/* verilog/pce_pad_pkg.sv */
//////////////////////////////////////////////////
// PC Engine controller formats
// Host gamepad word layout, console port word and
// the widths shared by the pad scan and mouse port
//////////////////////////////////////////////////

package pce_pad_pkg;

	localparam int num_pads = 5;   // Host pad slots on the multitap
	localparam int pad_bits = 12;

	// Host pad word bit positions
	localparam int bit_right = 0;
	localparam int bit_left  = 1;
	localparam int bit_down  = 2;
	localparam int bit_up    = 3;
	localparam int bit_i     = 4;
	localparam int bit_ii    = 5;
	localparam int bit_sel   = 6;
	localparam int bit_run   = 7;
	localparam int bit_iii   = 8;   // III to VI in bits 8 to 11

	typedef logic [pad_bits-1:0] pad_word_t;
	typedef logic [15:0]         port_word_t;   // Four nibbles, active low
	typedef logic [3:0]          nibble_t;
	typedef logic [2:0]          port_idx_t;

	// Ports past the last pad read as nothing pressed
	localparam port_word_t empty_port_word = 16'h0FFF;

	localparam int mouse_to_bits_default = 15;

endpackage

/* verilog/pce_regs_pkg.sv */
//////////////////////////////////////////////////
// Configuration register map
// AXI4-Lite widths, response codes, addresses and
// control field layout
//////////////////////////////////////////////////

package pce_regs_pkg;

	localparam int axi_addr_bits = 4;
	localparam int axi_data_bits = 32;
	localparam int axi_strb_bits = axi_data_bits / 8;

	// AXI response codes
	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// Register addresses
	localparam logic [axi_addr_bits-1:0] reg_ctrl_addr = 4'h0;
	localparam logic [axi_addr_bits-1:0] reg_id_addr   = 4'h4;

	// Read-only identification value
	localparam logic [axi_data_bits-1:0] core_id = 32'h5043_4549;

	// Control register fields
	localparam int ctrl_bits         = 3;
	localparam int ctrl_multitap_bit = 0;
	localparam int ctrl_six_btn_bit  = 1;
	localparam int ctrl_mouse_bit    = 2;

endpackage

/* verilog/pce_cfg_regs.sv */
//////////////////////////////////////////////////
// Controller configuration registers
// AXI4-Lite slave with one control register
// (multitap, six button, mouse) and an ID register.
// One write and one read in flight at a time.
//////////////////////////////////////////////////

`timescale 1ns/10ps

module pce_cfg_regs (
	input  logic                                    clk_sys,
	input  logic                                    reset,

	input  logic [pce_regs_pkg::axi_addr_bits-1:0]  awaddr,
	input  logic                                    awvalid,
	output logic                                    awready,
	input  logic [pce_regs_pkg::axi_data_bits-1:0]  wdata,
	input  logic [pce_regs_pkg::axi_strb_bits-1:0]  wstrb,
	input  logic                                    wvalid,
	output logic                                    wready,
	output logic [1:0]                              bresp,
	output logic                                    bvalid,
	input  logic                                    bready,
	input  logic [pce_regs_pkg::axi_addr_bits-1:0]  araddr,
	input  logic                                    arvalid,
	output logic                                    arready,
	output logic [pce_regs_pkg::axi_data_bits-1:0]  rdata,
	output logic [1:0]                              rresp,
	output logic                                    rvalid,
	input  logic                                    rready,

	output logic                                    multitap_en,
	output logic                                    six_btn_en,
	output logic                                    mouse_en
);

	logic [pce_regs_pkg::ctrl_bits-1:0]     ctrl;
	logic [pce_regs_pkg::axi_data_bits-1:0] rd_data;
	logic [1:0]                             rd_resp;
	logic                                   wr_hit;

	assign wr_hit = (awaddr == pce_regs_pkg::reg_ctrl_addr);

	//////////////////////////////////////////////////
	// Write channel

	// awready and wready pulse together, bvalid follows
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
			ctrl    <= '0;
		end else if (awready) begin
			awready <= 1'b0;   // Handshake completes this cycle
			wready  <= 1'b0;
			bvalid  <= 1'b1;
			if (wr_hit && wstrb[0])
				ctrl <= wdata[pce_regs_pkg::ctrl_bits-1:0];
		end else if (bvalid) begin
			if (bready)
				bvalid <= 1'b0;
		end else if (awvalid && wvalid) begin
			awready <= 1'b1;
			wready  <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (awready)
			bresp <= wr_hit ? pce_regs_pkg::resp_okay : pce_regs_pkg::resp_slverr;
	end

	//////////////////////////////////////////////////
	// Read channel

	// Address decode
	always_comb begin
		rd_data = '0;
		rd_resp = pce_regs_pkg::resp_okay;
		case (araddr)
			pce_regs_pkg::reg_ctrl_addr: rd_data[pce_regs_pkg::ctrl_bits-1:0] = ctrl;
			pce_regs_pkg::reg_id_addr:   rd_data = pce_regs_pkg::core_id;
			default:                     rd_resp = pce_regs_pkg::resp_slverr;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end else if (arvalid && arready) begin
			arready <= 1'b0;
			rvalid  <= 1'b1;
		end else if (rvalid) begin
			if (rready) begin
				rvalid  <= 1'b0;
				arready <= 1'b1;
			end
		end else begin
			arready <= 1'b1;   // Idle, ready for an address
		end
	end

	// Data held until rready
	always_ff @(posedge clk_sys) begin
		if (arvalid && arready) begin
			rdata <= rd_data;
			rresp <= rd_resp;
		end
	end

	assign multitap_en = ctrl[pce_regs_pkg::ctrl_multitap_bit];
	assign six_btn_en  = ctrl[pce_regs_pkg::ctrl_six_btn_bit];
	assign mouse_en    = ctrl[pce_regs_pkg::ctrl_mouse_bit];

endmodule

/* verilog/pce_pad_scan.sv */
//////////////////////////////////////////////////
// Controller port scan
// Encodes host pads into console words, walks the
// multitap ports on CLR/SEL and latches the nibble
// for the console. Handles the six button bank.
//////////////////////////////////////////////////

`timescale 1ns/10ps

module pce_pad_scan (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  pce_pad_pkg::pad_word_t   pad_0,
	input  pce_pad_pkg::pad_word_t   pad_1,
	input  pce_pad_pkg::pad_word_t   pad_2,
	input  pce_pad_pkg::pad_word_t   pad_3,
	input  pce_pad_pkg::pad_word_t   pad_4,
	input  logic [7:0]               mouse_byte,
	input  logic                     joy_clr,
	input  logic                     joy_sel,
	input  logic                     multitap_en,
	input  logic                     six_btn_en,
	input  logic                     mouse_en,
	output pce_pad_pkg::nibble_t     joy_in
);

	pce_pad_pkg::port_word_t port_data;
	pce_pad_pkg::port_idx_t  port_idx;
	pce_pad_pkg::nibble_t    joy_latch;
	logic                    bank;        // Set for buttons III to VI
	logic                    last_clr;
	logic                    last_sel;

	// Host pad word to active-low console word
	function automatic pce_pad_pkg::port_word_t encode_pad(
		input pce_pad_pkg::pad_word_t pad
	);
		encode_pad = ~{4'hF,
			pad[pce_pad_pkg::bit_iii +: 4],
			pad[pce_pad_pkg::bit_left], pad[pce_pad_pkg::bit_down],
			pad[pce_pad_pkg::bit_right], pad[pce_pad_pkg::bit_up],
			pad[pce_pad_pkg::bit_run], pad[pce_pad_pkg::bit_sel],
			pad[pce_pad_pkg::bit_ii], pad[pce_pad_pkg::bit_i]};
	endfunction

	// Word on the currently selected port
	always_comb begin
		case (port_idx)
			3'd0:    port_data = mouse_en ? {mouse_byte, mouse_byte} : encode_pad(pad_0);
			3'd1:    port_data = encode_pad(pad_1);
			3'd2:    port_data = encode_pad(pad_2);
			3'd3:    port_data = encode_pad(pad_3);
			3'd4:    port_data = encode_pad(pad_4);
			default: port_data = pce_pad_pkg::empty_port_word;
		endcase
	end

	//////////////////////////////////////////////////
	// Port walk and nibble latch

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			port_idx  <= '0;
			joy_latch <= '0;
			bank      <= 1'b0;
			last_clr  <= 1'b0;
			last_sel  <= 1'b0;
		end else begin
			last_clr  <= joy_clr;
			last_sel  <= joy_sel;
			joy_latch <= port_data[{bank, joy_sel, 2'b00} +: 4];

			if (joy_clr) begin
				port_idx  <= '0;
				joy_latch <= '0;   // Console reads 0 during clear
				if (!last_clr)
					bank <= ~bank & six_btn_en;
			end else if (joy_sel && !last_sel && multitap_en) begin
				port_idx <= port_idx + 3'd1;   // Next multitap port
			end
		end
	end

	assign joy_in = joy_latch;

endmodule

/* verilog/pce_mouse_port.sv */
//////////////////////////////////////////////////
// PC Engine mouse on port 0
// Latches host motion per packet and sends it as
// four nibbles, one per CLR pulse, with an idle
// timeout that restarts the sequence
//////////////////////////////////////////////////

`timescale 1ns/10ps

module pce_mouse_port #(
	parameter int mouse_to_bits = pce_pad_pkg::mouse_to_bits_default
) (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       joy_clr,
	input  logic [7:0] mouse_dx,
	input  logic [7:0] mouse_dy,
	input  logic [1:0] mouse_btn,   // Bit 0 left, bit 1 right
	input  logic       mouse_stb,   // Toggles per packet
	input  logic [1:0] run_sel,     // Run, Select from pad 0
	output logic [7:0] mouse_byte
);

	logic [1:0]               nib_cnt;
	logic [mouse_to_bits-1:0] idle_cnt;
	logic [7:0]               pend_x;
	logic [7:0]               pend_y;
	logic [7:0]               ms_x;
	logic [7:0]               ms_y;
	logic                     last_clr;
	logic                     last_stb;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			nib_cnt  <= 2'd3;
			idle_cnt <= '0;
			pend_x   <= '0;
			pend_y   <= '0;
			ms_x     <= '0;
			ms_y     <= '0;
			last_clr <= 1'b0;
			last_stb <= 1'b0;
		end else begin
			last_clr <= joy_clr;
			last_stb <= mouse_stb;

			// Idle timer runs only while CLR is low
			if (joy_clr)
				idle_cnt <= '0;
			else if (!(&idle_cnt))
				idle_cnt <= idle_cnt + 1'b1;

			if (&idle_cnt)
				nib_cnt <= 2'd3;

			if (joy_clr && !last_clr) begin
				nib_cnt <= nib_cnt + 2'd1;
				if (&nib_cnt) begin   // New frame, show pending motion
					ms_x   <= pend_x;
					ms_y   <= pend_y;
					pend_x <= '0;
					pend_y <= '0;
				end
			end

			if (mouse_stb ^ last_stb) begin
				pend_x <= 8'd0 - mouse_dx;
				pend_y <= 8'd0 - mouse_dy;
			end
		end
	end

	// Low nibble: Run, Select, left, right, all active low
	assign mouse_byte[3:0] = ~{run_sel, mouse_btn[0], mouse_btn[1]};

	always_comb begin
		case (nib_cnt)
			2'd0:    mouse_byte[7:4] = ms_x[7:4];
			2'd1:    mouse_byte[7:4] = ms_x[3:0];
			2'd2:    mouse_byte[7:4] = ms_y[7:4];
			default: mouse_byte[7:4] = ms_y[3:0];
		endcase
	end

endmodule

/* verilog/pce_input_top.sv */
//////////////////////////////////////////////////
// PC Engine controller port unit
// Register block, pad scan and mouse port
//////////////////////////////////////////////////

`timescale 1ns/10ps

module pce_input_top #(
	parameter int mouse_to_bits = pce_pad_pkg::mouse_to_bits_default
) (
	input  logic                                    clk_sys,
	input  logic                                    reset,

	input  logic [pce_regs_pkg::axi_addr_bits-1:0]  awaddr,
	input  logic                                    awvalid,
	output logic                                    awready,
	input  logic [pce_regs_pkg::axi_data_bits-1:0]  wdata,
	input  logic [pce_regs_pkg::axi_strb_bits-1:0]  wstrb,
	input  logic                                    wvalid,
	output logic                                    wready,
	output logic [1:0]                              bresp,
	output logic                                    bvalid,
	input  logic                                    bready,
	input  logic [pce_regs_pkg::axi_addr_bits-1:0]  araddr,
	input  logic                                    arvalid,
	output logic                                    arready,
	output logic [pce_regs_pkg::axi_data_bits-1:0]  rdata,
	output logic [1:0]                              rresp,
	output logic                                    rvalid,
	input  logic                                    rready,

	input  pce_pad_pkg::pad_word_t                  pad_0,
	input  pce_pad_pkg::pad_word_t                  pad_1,
	input  pce_pad_pkg::pad_word_t                  pad_2,
	input  pce_pad_pkg::pad_word_t                  pad_3,
	input  pce_pad_pkg::pad_word_t                  pad_4,

	input  logic [7:0]                              mouse_dx,
	input  logic [7:0]                              mouse_dy,
	input  logic [1:0]                              mouse_btn,
	input  logic                                    mouse_stb,

	input  logic                                    joy_clr,
	input  logic                                    joy_sel,
	output pce_pad_pkg::nibble_t                    joy_in
);

	logic       multitap_en;
	logic       six_btn_en;
	logic       mouse_en;
	logic [7:0] mouse_byte;

	pce_cfg_regs cfg_regs_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.awaddr      (awaddr),
		.awvalid     (awvalid),
		.awready     (awready),
		.wdata       (wdata),
		.wstrb       (wstrb),
		.wvalid      (wvalid),
		.wready      (wready),
		.bresp       (bresp),
		.bvalid      (bvalid),
		.bready      (bready),
		.araddr      (araddr),
		.arvalid     (arvalid),
		.arready     (arready),
		.rdata       (rdata),
		.rresp       (rresp),
		.rvalid      (rvalid),
		.rready      (rready),
		.multitap_en (multitap_en),
		.six_btn_en  (six_btn_en),
		.mouse_en    (mouse_en)
	);

	pce_pad_scan pad_scan_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.pad_0       (pad_0),
		.pad_1       (pad_1),
		.pad_2       (pad_2),
		.pad_3       (pad_3),
		.pad_4       (pad_4),
		.mouse_byte  (mouse_byte),
		.joy_clr     (joy_clr),
		.joy_sel     (joy_sel),
		.multitap_en (multitap_en),
		.six_btn_en  (six_btn_en),
		.mouse_en    (mouse_en),
		.joy_in      (joy_in)
	);

	// Mouse buttons share the low nibble with pad 0 Run and Select
	pce_mouse_port #(
		.mouse_to_bits (mouse_to_bits)
	) mouse_port_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.joy_clr    (joy_clr),
		.mouse_dx   (mouse_dx),
		.mouse_dy   (mouse_dy),
		.mouse_btn  (mouse_btn),
		.mouse_stb  (mouse_stb),
		.run_sel    ({pad_0[pce_pad_pkg::bit_run], pad_0[pce_pad_pkg::bit_sel]}),
		.mouse_byte (mouse_byte)
	);

endmodule

/* test/pce_input_properties.sv */
//////////////////////////////////////////////////
// AXI4-Lite response checks for the controller
// port unit, bound to the top level
//////////////////////////////////////////////////

`timescale 1ns/10ps

module pce_input_properties (
	input  logic                                    clk_sys,
	input  logic                                    reset,
	input  logic                                    awready,
	input  logic [1:0]                              bresp,
	input  logic                                    bvalid,
	input  logic                                    bready,
	input  logic [pce_regs_pkg::axi_data_bits-1:0]  rdata,
	input  logic [1:0]                              rresp,
	input  logic                                    rvalid,
	input  logic                                    rready
);

	// Write response stays until bready
	assert property (@(posedge clk_sys) disable iff (reset)
		(bvalid && !bready) |=> (bvalid && $stable(bresp)))
		else $error("Write response dropped or changed before bready");

	// Read data stays until rready
	assert property (@(posedge clk_sys) disable iff (reset)
		(rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rresp)))
		else $error("Read response dropped or changed before rready");

	assert property (@(posedge clk_sys) disable iff (reset)
		$rose(awready) |-> !$past(bvalid))
		else $error("awready rose while a write response was pending");

endmodule

bind pce_input_top pce_input_properties props_i (
	.clk_sys (clk_sys),
	.reset   (reset),
	.awready (awready),
	.bresp   (bresp),
	.bvalid  (bvalid),
	.bready  (bready),
	.rdata   (rdata),
	.rresp   (rresp),
	.rvalid  (rvalid),
	.rready  (rready)
);

/* test/tb_pce_input.sv */
//////////////////////////////////////////////////
// Testbench for the controller port unit
// Replays a trace of register accesses, pad and
// mouse stimuli and console steps, and compares
// joy_in and the AXI responses with the trace
//////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_pce_input;

	localparam int mouse_to_bits   = 6;
	localparam int step_cycles     = 4;    // Per console step
	localparam int cycles_per_line = 50;   // Watchdog budget

	logic                                    clk_sys;
	logic                                    reset;
	logic [pce_regs_pkg::axi_addr_bits-1:0]  awaddr;
	logic                                    awvalid;
	logic                                    awready;
	logic [pce_regs_pkg::axi_data_bits-1:0]  wdata;
	logic [pce_regs_pkg::axi_strb_bits-1:0]  wstrb;
	logic                                    wvalid;
	logic                                    wready;
	logic [1:0]                              bresp;
	logic                                    bvalid;
	logic                                    bready;
	logic [pce_regs_pkg::axi_addr_bits-1:0]  araddr;
	logic                                    arvalid;
	logic                                    arready;
	logic [pce_regs_pkg::axi_data_bits-1:0]  rdata;
	logic [1:0]                              rresp;
	logic                                    rvalid;
	logic                                    rready;
	pce_pad_pkg::pad_word_t                  pad_0, pad_1, pad_2, pad_3, pad_4;
	logic [7:0]                              mouse_dx;
	logic [7:0]                              mouse_dy;
	logic [1:0]                              mouse_btn;
	logic                                    mouse_stb;
	logic                                    joy_clr;
	logic                                    joy_sel;
	pce_pad_pkg::nibble_t                    joy_in;

	string line_q[$];     // Trace lines without comments
	int    line_count;
	int    checks;
	int    value_errors;
	int    other_errors;

	pce_input_top #(
		.mouse_to_bits (mouse_to_bits)
	) dut_i (
		.clk_sys (clk_sys), .reset (reset),
		.awaddr (awaddr), .awvalid (awvalid), .awready (awready),
		.wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
		.bresp (bresp), .bvalid (bvalid), .bready (bready),
		.araddr (araddr), .arvalid (arvalid), .arready (arready),
		.rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
		.pad_0 (pad_0), .pad_1 (pad_1), .pad_2 (pad_2), .pad_3 (pad_3), .pad_4 (pad_4),
		.mouse_dx (mouse_dx), .mouse_dy (mouse_dy), .mouse_btn (mouse_btn),
		.mouse_stb (mouse_stb),
		.joy_clr (joy_clr), .joy_sel (joy_sel), .joy_in (joy_in)
	);

	initial clk_sys = 1'b0;
	always #5 clk_sys = ~clk_sys;   // 10 ns period

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			value_errors++;
			$display("Fail at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic load_trace();
		int    fd;
		int    code;
		string line;
		fd = $fopen("test/pce_input_trace.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("Could not open the trace file test/pce_input_trace.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				code = $fgets(line, fd);
				if (code > 0 && line.len() > 1 && line[0] != "#")
					line_q.push_back(line);
			end
			$fclose(fd);
		end
	endtask

	//////////////////////////////////////////////////
	// Bus and port drivers, all on the falling edge

	task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [31:0] strb, input logic [31:0] exp_resp, input int stall);
		int rounds;
		int round;
		rounds  = (stall > 0) ? 2 : 1;   // A stalled write is offered again behind it
		awaddr  = addr[pce_regs_pkg::axi_addr_bits-1:0];
		wdata   = data;
		wstrb   = strb[pce_regs_pkg::axi_strb_bits-1:0];
		awvalid = 1'b1;
		wvalid  = 1'b1;
		bready  = 1'b0;
		for (round = 0; round < rounds; round++) begin
			while (!awready) @(negedge clk_sys);
			check_value("wready", {31'd0, wready}, 32'd1);
			@(negedge clk_sys);   // Handshake on the edge in between
			awvalid = 1'b0;
			wvalid  = 1'b0;
			while (!bvalid) @(negedge clk_sys);
			if (round == 0 && stall > 0) begin
				awvalid = 1'b1;   // Next write waits on the pending response
				wvalid  = 1'b1;
				repeat (stall) begin
					check_value("bresp", {30'd0, bresp}, exp_resp);
					check_value("awready", {31'd0, awready}, 32'd0);
					@(negedge clk_sys);
				end
			end
			check_value("bresp", {30'd0, bresp}, exp_resp);
			check_value("bvalid", {31'd0, bvalid}, 32'd1);
			bready = 1'b1;
			@(negedge clk_sys);
			bready = 1'b0;
		end
	endtask

	task automatic axi_read(input logic [31:0] addr, input logic [31:0] exp_data,
		input logic [31:0] exp_resp, input int stall);
		araddr  = addr[pce_regs_pkg::axi_addr_bits-1:0];
		arvalid = 1'b1;
		rready  = 1'b0;
		while (!arready) @(negedge clk_sys);
		@(negedge clk_sys);
		arvalid = 1'b0;
		while (!rvalid) @(negedge clk_sys);
		repeat (stall) begin
			check_value("rdata", rdata, exp_data);   // Held under back-pressure
			check_value("arready", {31'd0, arready}, 32'd0);
			@(negedge clk_sys);
		end
		check_value("rdata", rdata, exp_data);
		check_value("rresp", {30'd0, rresp}, exp_resp);
		check_value("rvalid", {31'd0, rvalid}, 32'd1);
		rready = 1'b1;
		@(negedge clk_sys);
		rready = 1'b0;
	endtask

	task automatic set_pad(input logic [31:0] idx, input logic [31:0] value);
		case (idx)
			0:       pad_0 = value[11:0];
			1:       pad_1 = value[11:0];
			2:       pad_2 = value[11:0];
			3:       pad_3 = value[11:0];
			4:       pad_4 = value[11:0];
			default: begin
				other_errors++;
				$display("Trace names pad %0d, which does not exist", idx);
			end
		endcase
	endtask

	// New packet, strobe toggles once
	task automatic send_mouse(input logic [31:0] dx, input logic [31:0] dy,
		input logic [31:0] btn);
		mouse_dx  = dx[7:0];
		mouse_dy  = dy[7:0];
		mouse_btn = btn[1:0];
		mouse_stb = ~mouse_stb;
		repeat (step_cycles) @(negedge clk_sys);
	endtask

	task automatic console_step(input logic clr, input logic sel, input logic [31:0] expected);
		joy_clr = clr;
		joy_sel = sel;
		repeat (step_cycles) @(negedge clk_sys);
		check_value("joy_in", {28'd0, joy_in}, expected);
	endtask

	task automatic run_line(input string line);
		logic [7:0]  op;
		logic [31:0] f1, f2, f3, f4, f5;
		int          n;
		f1 = '0;
		f2 = '0;
		f3 = '0;
		f4 = '0;
		f5 = '0;
		n = $sscanf(line, "%c %h %h %h %h %h", op, f1, f2, f3, f4, f5);
		case (op)
			"W": axi_write(f1, f2, f3, f4, int'(f5));
			"R": axi_read(f1, f2, f3, int'(f4));
			"P": set_pad(f1, f2);
			"M": send_mouse(f1, f2, f3);
			"C": console_step(f1[0], f2[0], f3);
			"I": repeat (f1) @(negedge clk_sys);
			default: begin
				other_errors++;
				$display("Unknown trace operation in line (%0d fields): %s", n, line);
			end
		endcase
	endtask

	//////////////////////////////////////////////////
	// Main sequence

	initial begin
		reset     = 1'b1;
		awaddr    = '0;
		awvalid   = 1'b0;
		wdata     = '0;
		wstrb     = '0;
		wvalid    = 1'b0;
		bready    = 1'b0;
		araddr    = '0;
		arvalid   = 1'b0;
		rready    = 1'b0;
		pad_0     = '0;
		pad_1     = '0;
		pad_2     = '0;
		pad_3     = '0;
		pad_4     = '0;
		mouse_dx  = '0;
		mouse_dy  = '0;
		mouse_btn = '0;
		mouse_stb = 1'b0;
		joy_clr   = 1'b1;   // Console holds CLR at start
		joy_sel   = 1'b1;
		checks       = 0;
		value_errors = 0;
		other_errors = 0;

		load_trace();
		line_count = line_q.size();
		if (line_count == 0 && other_errors == 0) begin
			other_errors++;
			$display("The trace file holds no steps");
		end

		repeat (8) @(negedge clk_sys);
		reset = 1'b0;
		check_value("joy_in", {28'd0, joy_in}, 32'd0);
		check_value("bvalid", {31'd0, bvalid}, 32'd0);
		check_value("rvalid", {31'd0, rvalid}, 32'd0);
		check_value("awready", {31'd0, awready}, 32'd0);
		check_value("wready", {31'd0, wready}, 32'd0);
		check_value("arready", {31'd0, arready}, 32'd0);

		foreach (line_q[i])
			run_line(line_q[i]);

		repeat (2) @(negedge clk_sys);
		$display("Checks %0d, value errors %0d, other errors %0d",
			checks, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// Watchdog scaled by the trace length
	initial begin
		wait (line_count > 0);
		repeat (line_count * cycles_per_line) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles, the trace did not finish",
			line_count * cycles_per_line);
		$display("TB FAILED");
		$finish;
	end

endmodule

/* all.f */
verilog/pce_pad_pkg.sv
verilog/pce_regs_pkg.sv
verilog/pce_cfg_regs.sv
verilog/pce_pad_scan.sv
verilog/pce_mouse_port.sv
verilog/pce_input_top.sv
test/pce_input_properties.sv
test/tb_pce_input.sv

/* run_sim.sh */
#!/bin/bash
# Build the controller port testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_pce_input \
	-f all.f -o tb_pce_input > build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/tb_pce_input > sim.log 2>&1 || echo "Simulation exited with an error status"

grep -qx "TB PASSED" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

/* test/pce_input_trace.txt */
# op fields, hex: W addr data strb bresp stall | R addr rdata rresp stall
# P pad value | M dx dy btn | C clr sel joy_in | I idle_cycles
W 0 7 F 0 0
R 0 7 0 0
W 0 0 2 0 0
R 0 7 0 3
W 0 FFFFFFFA F 0 5
R 0 2 0 0
R 4 50434549 0 6
W 8 1 F 2 0
R 0 2 0 0
R C 0 2 0
R 8 0 2 2
P 0 0A5
P 1 31C
P 2 0F0
P 3 00F
P 4 842
# Single pad
W 0 0 F 0 0
C 0 1 9
C 0 0 5
C 0 1 9
C 0 0 5
C 1 1 0
# Multitap scan of five pads, then empty ports
W 0 1 F 0 0
C 0 1 9
C 0 0 5
C 0 1 A
C 0 0 E
C 0 1 F
C 0 0 0
C 0 1 0
C 0 0 F
C 0 1 7
C 0 0 B
C 0 1 F
C 0 0 F
C 1 1 0
# Six-button bank with multitap
W 0 3 F 0 0
C 0 1 9
C 1 1 0
C 0 1 0
C 0 0 F
C 0 1 0
C 0 0 C
C 1 1 0
C 0 1 9
C 0 0 5
C 0 1 A
C 0 0 E
C 1 1 0
C 0 1 0
C 0 0 F
C 1 1 0
# Mouse on port 0
W 0 4 F 0 0
C 0 0 7
M 25 F3 2
I 50
C 1 1 0
C 0 1 D
C 0 0 6
C 1 1 0
C 0 1 B
C 0 0 6
C 1 1 0
C 0 1 0
C 0 0 6
C 1 1 0
C 0 1 D
C 0 0 6
M 70 01 2
C 1 1 0
C 0 1 9
C 0 0 6
C 1 1 0
C 0 1 0
C 0 0 6
M C0 00 1
C 0 0 5
# Idle CLR, sequence restarts at X high
I 50
C 1 1 0
C 0 1 4
C 0 0 5
